/* verilog/rename_geom_pkg.sv */
// ####################
// Register file and checkpoint geometry of the rename unit
// The typedef widths are sized for these defaults; module parameters
// may change the array sizes only while the values fit these widths
// ####################
package rename_geom_pkg;

  // Architectural and physical integer register counts
  parameter int arf_count = 32;
  parameter int prf_count = 64;

  // Branch checkpoints that can be live at once
  parameter int cp_count = 4;

  typedef logic [4:0] arf_index_t;
  typedef logic [5:0] prf_index_t;
  typedef logic [1:0] cp_index_t;

  // Free list occupancy, holds 0 up to prf_count
  typedef logic [6:0] free_count_t;

endpackage

/* verilog/rename_op_pkg.sv */
// ####################
// Operation kinds, status codes and control states of the rename unit
// ####################
package rename_op_pkg;

  typedef enum logic [1:0] {
    op_rename  = 2'd0,
    op_retire  = 2'd1,
    op_recover = 2'd2
  } rename_op_e;

  // Any status other than st_ok leaves all tables untouched
  typedef enum logic [1:0] {
    st_ok             = 2'd0,
    st_no_free        = 2'd1,
    st_no_checkpoint  = 2'd2,
    st_bad_checkpoint = 2'd3
  } rename_status_e;

  typedef enum logic [1:0] {
    cs_idle, cs_execute, cs_respond, cs_release
  } control_state_e;

endpackage

/* verilog/map_table.sv */
// ####################
// Architectural to physical register map with full-copy checkpoints
// Reset maps register i to physical register i
// ####################
`timescale 1ns/1ps

module map_table #(
  parameter int ARF_COUNT = rename_geom_pkg::arf_count,
  parameter int CP_COUNT  = rename_geom_pkg::cp_count
) (
  input  logic clock,
  input  logic reset,
  input  rename_geom_pkg::arf_index_t rs1,
  input  rename_geom_pkg::arf_index_t rs2,
  input  rename_geom_pkg::arf_index_t rd,
  input  rename_geom_pkg::prf_index_t new_prd,
  input  logic write,
  input  logic snapshot,
  input  logic restore,
  input  rename_geom_pkg::cp_index_t cp_sel,
  output rename_geom_pkg::prf_index_t prs1,
  output rename_geom_pkg::prf_index_t prs2,
  output rename_geom_pkg::prf_index_t prev_prd
);

  rename_geom_pkg::prf_index_t map [ARF_COUNT];
  rename_geom_pkg::prf_index_t map_next [ARF_COUNT];
  rename_geom_pkg::prf_index_t snap [CP_COUNT][ARF_COUNT];

  // Reads come from the current map, before this cycle's write
  assign prs1     = map[rs1];
  assign prs2     = map[rs2];
  assign prev_prd = map[rd];

  always_comb begin
    map_next = map;
    if (write)
      map_next[rd] = new_prd;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < ARF_COUNT; i++)
        map[i] <= rename_geom_pkg::prf_index_t'(i);
    end else if (restore) begin
      map <= snap[cp_sel];
    end else begin
      map <= map_next;
    end
  end

  // A branch snapshot already holds the branch's own destination
  always_ff @(posedge clock) begin
    if (snapshot)
      snap[cp_sel] <= map_next;
  end

endmodule

/* verilog/free_list.sv */
// ####################
// Circular queue of free physical registers, PRF_COUNT-ARF_COUNT deep
// Restore rewinds only the head, registers freed since the snapshot stay
// ####################
`timescale 1ns/1ps

module free_list #(
  parameter int PRF_COUNT = rename_geom_pkg::prf_count,
  parameter int ARF_COUNT = rename_geom_pkg::arf_count,
  parameter int CP_COUNT  = rename_geom_pkg::cp_count
) (
  input  logic clock,
  input  logic reset,
  input  logic pop,
  input  logic push,
  input  rename_geom_pkg::prf_index_t push_prd,
  input  logic snapshot,
  input  logic restore,
  input  rename_geom_pkg::cp_index_t cp_sel,
  output rename_geom_pkg::prf_index_t head_prd,
  output logic free_empty
);

  localparam int DEPTH = PRF_COUNT - ARF_COUNT;
  localparam int SLOT_W = $clog2(DEPTH);

  typedef logic [SLOT_W-1:0] slot_t;

  rename_geom_pkg::prf_index_t queue [DEPTH];
  slot_t saved_head [CP_COUNT];
  slot_t head, head_next, tail;
  rename_geom_pkg::free_count_t count;
  rename_geom_pkg::free_count_t rollback;

  function automatic slot_t step(input slot_t idx);
    return (int'(idx) == DEPTH - 1) ? '0 : slot_t'(idx + 1'b1);
  endfunction

  assign head_prd   = queue[head];
  assign free_empty = (count == '0);
  assign head_next  = pop ? step(head) : head;

  // Entries handed out since the snapshot, they become free again
  always_comb begin
    if (head >= saved_head[cp_sel])
      rollback = rename_geom_pkg::free_count_t'(head - saved_head[cp_sel]);
    else
      rollback = rename_geom_pkg::free_count_t'(DEPTH + head - saved_head[cp_sel]);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= rename_geom_pkg::free_count_t'(DEPTH);
      for (int i = 0; i < DEPTH; i++)
        queue[i] <= rename_geom_pkg::prf_index_t'(ARF_COUNT + i);
    end else if (restore) begin
      head  <= saved_head[cp_sel];
      count <= count + rollback;
    end else if (push) begin
      queue[tail] <= push_prd;
      tail        <= step(tail);
      count       <= count + 1'b1;
    end else if (pop) begin
      head  <= head_next;
      count <= count - 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (snapshot)
      saved_head[cp_sel] <= head_next;
  end

endmodule

/* verilog/checkpoint_ring.sv */
// ####################
// Checkpoint slots handed out and freed in program order
// Release with no live slot is ignored
// ####################
`timescale 1ns/1ps

module checkpoint_ring #(
  parameter int CP_COUNT = rename_geom_pkg::cp_count
) (
  input  logic clock,
  input  logic reset,
  input  logic alloc,
  input  logic release_cp,
  input  logic discard,
  input  rename_geom_pkg::cp_index_t recover_cp,
  output rename_geom_pkg::cp_index_t new_cp,
  output logic ring_full,
  output logic cp_live
);

  localparam int LIVE_W = $clog2(CP_COUNT + 1);

  rename_geom_pkg::cp_index_t oldest;
  rename_geom_pkg::cp_index_t distance;
  logic [LIVE_W-1:0] live;

  function automatic rename_geom_pkg::cp_index_t wrap(input int value);
    return rename_geom_pkg::cp_index_t'(value % CP_COUNT);
  endfunction

  // Age of recover_cp counted from the oldest slot
  assign distance  = wrap(int'(recover_cp) + CP_COUNT - int'(oldest));
  assign cp_live   = LIVE_W'(distance) < live;
  assign new_cp    = wrap(int'(oldest) + int'(live));
  assign ring_full = (live == LIVE_W'(CP_COUNT));

  always_ff @(posedge clock) begin
    if (reset) begin
      oldest <= '0;
      live   <= '0;
    end else if (discard) begin
      live <= LIVE_W'(distance);
    end else if (alloc) begin
      live <= live + 1'b1;
    end else if (release_cp && live != '0) begin
      oldest <= wrap(int'(oldest) + 1);
      live   <= live - 1'b1;
    end
  end

endmodule

/* verilog/rename_control.sv */
// ####################
// Four-phase req/ack sequencer, one operation in flight at a time
// Inputs must be stable while req is high; results hold while ack is high
// ####################
`timescale 1ns/1ps

module rename_control (
  input  logic clock,
  input  logic reset,
  input  logic req,
  output logic ack,
  input  rename_op_pkg::rename_op_e op,
  input  rename_geom_pkg::arf_index_t rs1, rs2, rd,
  input  logic rd_valid, is_branch,
  input  rename_geom_pkg::prf_index_t retire_prev_prd,
  input  logic retire_prev_valid, retire_is_branch,
  input  rename_geom_pkg::cp_index_t recover_cp,
  input  logic free_empty, ring_full, cp_live,
  input  rename_geom_pkg::prf_index_t map_prs1, map_prs2, map_prev_prd, head_prd,
  input  rename_geom_pkg::cp_index_t new_cp,
  output rename_op_pkg::rename_status_e status,
  output rename_geom_pkg::prf_index_t prs1, prs2, prd, prev_prd,
  output logic prev_valid,
  output rename_geom_pkg::cp_index_t cp_id,
  output logic map_write, map_snapshot, map_restore,
  output logic fl_pop, fl_push, fl_snapshot, fl_restore,
  output logic cp_alloc, cp_release, cp_discard,
  output logic latch_enable,
  output rename_geom_pkg::cp_index_t cp_sel,
  output rename_geom_pkg::arf_index_t rs1_q, rs2_q, rd_q,
  output rename_geom_pkg::prf_index_t retire_prd_q,
  output rename_geom_pkg::cp_index_t recover_cp_q
);

  rename_op_pkg::control_state_e state;
  rename_op_pkg::rename_op_e op_q;
  rename_op_pkg::rename_status_e status_now;
  logic rd_valid_q, is_branch_q;
  logic retire_valid_q, retire_branch_q;
  logic exec_ok;

  assign latch_enable = (state == rename_op_pkg::cs_idle) && req;

  // Capacity check, only meaningful while in execute
  always_comb begin
    status_now = rename_op_pkg::st_ok;
    if (op_q == rename_op_pkg::op_rename) begin
      if (rd_valid_q && free_empty)
        status_now = rename_op_pkg::st_no_free;
      else if (is_branch_q && ring_full)
        status_now = rename_op_pkg::st_no_checkpoint;
    end else if (op_q == rename_op_pkg::op_recover && !cp_live) begin
      status_now = rename_op_pkg::st_bad_checkpoint;
    end
  end

  assign exec_ok = (state == rename_op_pkg::cs_execute) && (status_now == rename_op_pkg::st_ok);

  assign map_write    = exec_ok && op_q == rename_op_pkg::op_rename && rd_valid_q;
  assign fl_pop       = map_write;
  assign cp_alloc     = exec_ok && op_q == rename_op_pkg::op_rename && is_branch_q;
  assign map_snapshot = cp_alloc;
  assign fl_snapshot  = cp_alloc;
  assign fl_push      = exec_ok && op_q == rename_op_pkg::op_retire && retire_valid_q;
  assign cp_release   = exec_ok && op_q == rename_op_pkg::op_retire && retire_branch_q;
  assign cp_discard   = exec_ok && op_q == rename_op_pkg::op_recover;
  assign map_restore  = cp_discard;
  assign fl_restore   = cp_discard;

  // Snapshots go to the next free slot, restores come from the named one
  assign cp_sel = (op_q == rename_op_pkg::op_recover) ? recover_cp_q : new_cp;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= rename_op_pkg::cs_idle;
      ack   <= 1'b0;
    end else begin
      case (state)
        rename_op_pkg::cs_idle: if (req) state <= rename_op_pkg::cs_execute;
        rename_op_pkg::cs_execute: state <= rename_op_pkg::cs_respond;
        rename_op_pkg::cs_respond: begin
          if (!ack) begin
            ack <= 1'b1;
          end else if (!req) begin
            ack   <= 1'b0;
            state <= rename_op_pkg::cs_release;
          end
        end
        default: state <= rename_op_pkg::cs_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (latch_enable) begin
      op_q            <= op;
      rs1_q           <= rs1;
      rs2_q           <= rs2;
      rd_q            <= rd;
      rd_valid_q      <= rd_valid;
      is_branch_q     <= is_branch;
      retire_prd_q    <= retire_prev_prd;
      retire_valid_q  <= retire_prev_valid;
      retire_branch_q <= retire_is_branch;
      recover_cp_q    <= recover_cp;
    end
    // Map reads here still see the mapping from before this write
    if (state == rename_op_pkg::cs_execute) begin
      status     <= status_now;
      prs1       <= map_prs1;
      prs2       <= map_prs2;
      prd        <= head_prd;
      prev_prd   <= map_prev_prd;
      prev_valid <= map_write;
      cp_id      <= cp_sel;
    end
  end

endmodule

/* verilog/rename_unit.sv */
// ####################
// Register rename unit, one operation per four-phase req/ack handshake
// ####################
`timescale 1ns/1ps

module rename_unit #(
  parameter int ARF_COUNT = rename_geom_pkg::arf_count,
  parameter int PRF_COUNT = rename_geom_pkg::prf_count,
  parameter int CP_COUNT  = rename_geom_pkg::cp_count
) (
  input  logic clock,
  input  logic reset,
  input  logic req,
  output logic ack,
  input  rename_op_pkg::rename_op_e op,
  input  rename_geom_pkg::arf_index_t rs1, rs2, rd,
  input  logic rd_valid, is_branch,
  input  rename_geom_pkg::prf_index_t retire_prev_prd,
  input  logic retire_prev_valid, retire_is_branch,
  input  rename_geom_pkg::cp_index_t recover_cp,
  output rename_geom_pkg::prf_index_t prs1, prs2, prd, prev_prd,
  output logic prev_valid,
  output rename_geom_pkg::cp_index_t cp_id,
  output rename_op_pkg::rename_status_e status
);

  rename_geom_pkg::prf_index_t map_prs1, map_prs2, map_prev_prd, head_prd, retire_prd_q;
  rename_geom_pkg::arf_index_t rs1_q, rs2_q, rd_q;
  rename_geom_pkg::cp_index_t new_cp, cp_sel, recover_cp_q;
  logic free_empty, ring_full, cp_live;
  logic map_write, map_snapshot, map_restore;
  logic fl_pop, fl_push, fl_snapshot, fl_restore;
  logic cp_alloc, cp_release, cp_discard;

  rename_control control0 (
    .clock, .reset, .req, .ack, .op, .rs1, .rs2, .rd, .rd_valid, .is_branch,
    .retire_prev_prd, .retire_prev_valid, .retire_is_branch, .recover_cp,
    .free_empty, .ring_full, .cp_live,
    .map_prs1, .map_prs2, .map_prev_prd, .head_prd, .new_cp,
    .status, .prs1, .prs2, .prd, .prev_prd, .prev_valid, .cp_id,
    .map_write, .map_snapshot, .map_restore,
    .fl_pop, .fl_push, .fl_snapshot, .fl_restore,
    .cp_alloc, .cp_release, .cp_discard,
    .latch_enable (),
    .cp_sel, .rs1_q, .rs2_q, .rd_q, .retire_prd_q, .recover_cp_q
  );

  map_table #(.ARF_COUNT(ARF_COUNT), .CP_COUNT(CP_COUNT)) map0 (
    .clock, .reset, .rs1(rs1_q), .rs2(rs2_q), .rd(rd_q), .new_prd(head_prd),
    .write(map_write), .snapshot(map_snapshot), .restore(map_restore), .cp_sel,
    .prs1(map_prs1), .prs2(map_prs2), .prev_prd(map_prev_prd)
  );

  free_list #(.PRF_COUNT(PRF_COUNT), .ARF_COUNT(ARF_COUNT), .CP_COUNT(CP_COUNT)) free0 (
    .clock, .reset, .pop(fl_pop), .push(fl_push), .push_prd(retire_prd_q),
    .snapshot(fl_snapshot), .restore(fl_restore), .cp_sel, .head_prd, .free_empty
  );

  checkpoint_ring #(.CP_COUNT(CP_COUNT)) ring0 (
    .clock, .reset, .alloc(cp_alloc), .release_cp(cp_release), .discard(cp_discard),
    .recover_cp(recover_cp_q), .new_cp, .ring_full, .cp_live
  );

endmodule

/* bench/rename_unit_tb.sv */
// ####################
// Replays bench/rename_trace.txt through the rename unit, one handshake per line
// Must run from the project root so the trace path resolves
// ####################
`timescale 1ns/1ps

module rename_unit_tb;

  localparam int timeout_cycles = 40;

  logic clock, reset, req, ack;
  rename_op_pkg::rename_op_e op;
  rename_geom_pkg::arf_index_t rs1, rs2, rd;
  logic rd_valid, is_branch, retire_prev_valid, retire_is_branch, prev_valid;
  rename_geom_pkg::prf_index_t retire_prev_prd, prs1, prs2, prd, prev_prd;
  rename_geom_pkg::cp_index_t recover_cp, cp_id;
  rename_op_pkg::rename_status_e status;

  int errors, timeouts, ops, fd, code;
  string name;
  logic [8*160-1:0] rest;
  // Stimulus fields and expected results of the current trace line
  int f [11];
  int e [7];

  rename_unit dut0 (
    .clock, .reset, .req, .ack, .op, .rs1, .rs2, .rd, .rd_valid, .is_branch,
    .retire_prev_prd, .retire_prev_valid, .retire_is_branch, .recover_cp,
    .prs1, .prs2, .prd, .prev_prd, .prev_valid, .cp_id, .status
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic check_prf(input string test, input string field,
                           input rename_geom_pkg::prf_index_t expected, actual);
    if (actual !== expected) begin
      errors++;
      $display("ERR %s %s expected %0d actual %0d", test, field, expected, actual);
    end
  endtask

  task automatic check_cp(input string test, input rename_geom_pkg::cp_index_t expected, actual);
    if (actual !== expected) begin
      errors++;
      $display("ERR %s cp_id expected %0d actual %0d", test, expected, actual);
    end
  endtask

  task automatic check_status(input string test,
                              input rename_op_pkg::rename_status_e expected, actual);
    if (actual !== expected) begin
      errors++;
      $display("ERR %s status expected %s actual %s", test, expected.name(), actual.name());
    end
  endtask

  task automatic check_bit(input string test, input logic expected, actual);
    if (actual !== expected) begin
      errors++;
      $display("ERR %s prev_valid expected %b actual %b", test, expected, actual);
    end
  endtask

  // Polls ack on falling edges, where the registered outputs are settled
  task automatic wait_for_ack(input logic level, input string test, output logic seen);
    int n;
    n = 0;
    while (ack !== level && n < timeout_cycles) begin
      @(negedge clock);
      n++;
    end
    seen = (ack === level);
    if (!seen) begin
      timeouts++;
      $display("Timeout in %s: ack did not go %s within %0d cycles",
               test, level ? "high" : "low", timeout_cycles);
    end
  endtask

  task automatic run_op(input string test, input bit check_all);
    logic seen;
    @(negedge clock);
    op                = rename_op_pkg::rename_op_e'(f[0]);
    rs1               = rename_geom_pkg::arf_index_t'(f[1]);
    rs2               = rename_geom_pkg::arf_index_t'(f[2]);
    rd                = rename_geom_pkg::arf_index_t'(f[3]);
    rd_valid          = (f[4] != 0);
    is_branch         = (f[5] != 0);
    retire_prev_prd   = rename_geom_pkg::prf_index_t'(f[6]);
    retire_prev_valid = (f[7] != 0);
    retire_is_branch  = (f[8] != 0);
    recover_cp        = rename_geom_pkg::cp_index_t'(f[9]);
    req               = 1'b1;
    wait_for_ack(1'b1, test, seen);
    if (seen) begin
      check_status(test, rename_op_pkg::rename_status_e'(e[6]), status);
      // Only the last of a repeated line has known table outputs
      if (check_all) begin
        check_prf(test, "prs1", rename_geom_pkg::prf_index_t'(e[0]), prs1);
        check_prf(test, "prs2", rename_geom_pkg::prf_index_t'(e[1]), prs2);
        check_prf(test, "prd", rename_geom_pkg::prf_index_t'(e[2]), prd);
        check_prf(test, "prev_prd", rename_geom_pkg::prf_index_t'(e[3]), prev_prd);
        check_bit(test, (e[4] != 0), prev_valid);
        check_cp(test, rename_geom_pkg::cp_index_t'(e[5]), cp_id);
      end
    end
    req = 1'b0;
    wait_for_ack(1'b0, test, seen);
    ops++;
  endtask

  initial begin
    errors = 0;
    timeouts = 0;
    ops = 0;
    reset = 1'b1;
    req = 1'b0;
    op = rename_op_pkg::op_rename;
    {rs1, rs2, rd, rd_valid, is_branch} = '0;
    {retire_prev_prd, retire_prev_valid, retire_is_branch, recover_cp} = '0;
    repeat (5) @(negedge clock);
    reset = 1'b0;
    fd = $fopen("bench/rename_trace.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the trace file bench/rename_trace.txt");
    end else begin
      code = $fscanf(fd, "%s", name);
      while (code == 1) begin
        if (name[0] == "#") begin
          code = $fgets(rest, fd);
        end else begin
          code = $fscanf(fd, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                         f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                         e[0], e[1], e[2], e[3], e[4], e[5], e[6]);
          if (code != 18) begin
            errors++;
            $display("Trace line %s is incomplete, only %0d of 18 fields read", name, code);
          end else begin
            for (int r = 1; r <= f[10]; r++)
              run_op(name, r == f[10]);
          end
        end
        code = $fscanf(fd, "%s", name);
      end
      $fclose(fd);
    end
    if (ops == 0) begin
      errors++;
      $display("No operations were read from the trace");
    end
    $display("Rename unit run: %0d operations, %0d errors, %0d timeouts", ops, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* bench/rename_trace.txt */
# name op rs1 rs2 rd rd_valid is_branch retire_prd retire_valid retire_branch recover_cp repeat
#   then expected prs1 prs2 prd prev_prd prev_valid cp_id status, all decimal
# op 0 rename 1 retire 2 recover, status 0 ok 1 no_free 2 no_checkpoint 3 bad_checkpoint
# Renames from reset read the identity map, destinations come from 32 up
rn_first     0 1 2 3 1 0 0 0 0 0 1   1 2 32 3 1 0 0
rn_raw       0 3 1 4 1 0 0 0 0 0 1   32 1 33 4 1 0 0
# Branches take slots 0 to 3, a fifth one is refused
br_cp0       0 4 3 5 1 1 0 0 0 0 1   33 32 34 5 1 0 0
rn_after_br  0 5 4 3 1 0 0 0 0 0 1   34 33 35 32 1 1 0
br_cp1       0 3 0 6 1 1 0 0 0 0 1   35 0 36 6 1 1 0
br_cp2_nodst 0 0 0 0 0 1 0 0 0 0 1   0 0 37 0 0 2 0
br_cp3       0 6 5 7 1 1 0 0 0 0 1   36 34 37 7 1 3 0
br_full      0 1 2 8 1 1 0 0 0 0 1   1 2 38 8 0 0 2
# Branch retire frees slot 0 for the next branch
ret_branch   1 0 0 0 0 0 3 1 1 0 1   0 0 38 0 0 0 0
br_reuse_cp0 0 7 3 8 1 1 0 0 0 0 1   37 35 38 8 1 0 0
# Recover to slot 1 drops it and every younger slot
rec_cp1      2 0 0 0 0 0 0 0 0 1 1   0 0 39 0 0 1 0
rn_after_rec 0 6 7 9 1 0 0 0 0 0 1   36 7 37 9 1 1 0
rec_dead     2 0 0 0 0 0 0 0 0 2 1   0 0 38 0 0 2 3
# Retired registers join the tail, drain the list and then reuse them
ret_p32      1 0 0 0 0 0 32 1 0 0 1  0 0 38 0 0 1 0
ret_p9       1 0 0 0 0 0 9 1 0 0 1   0 0 38 0 0 1 0
drain        0 0 0 11 1 0 0 0 0 0 26 0 0 63 62 1 1 0
reuse_p3     0 11 0 12 1 0 0 0 0 0 1 63 0 3 12 1 1 0
reuse_p32    0 12 11 13 1 0 0 0 0 0 1 3 63 32 13 1 1 0
reuse_p9     0 13 0 14 1 0 0 0 0 0 1 32 0 9 14 1 1 0
rn_no_free   0 14 0 15 1 0 0 0 0 0 1 9 0 35 15 0 1 1
rn_no_dst    0 14 13 0 0 0 0 0 0 0 1 9 32 35 0 0 1 0
ret_p33      1 0 0 0 0 0 33 1 0 0 1  0 0 35 0 0 1 0
reuse_p33    0 15 0 15 1 0 0 0 0 0 1 15 0 33 15 1 1 0
# A fresh branch after recovery takes slot 1 again
br_cp1_again 0 0 0 0 0 1 0 0 0 0 1   0 0 36 0 0 1 0
rec_cp1_b    2 0 0 0 0 0 0 0 0 1 1   0 0 36 0 0 1 0
rec_cp1_dead 2 0 0 0 0 0 0 0 0 1 1   0 0 36 0 0 1 3

/* rename_unit.f */
verilog/rename_geom_pkg.sv
verilog/rename_op_pkg.sv
verilog/map_table.sv
verilog/free_list.sv
verilog/checkpoint_ring.sv
verilog/rename_control.sv
verilog/rename_unit.sv
bench/rename_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the rename unit testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f rename_unit.f --top-module rename_unit_tb -o rename_sim

./obj_dir/rename_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi
echo "Simulation finished without a failure report"
